/* uc_consts.svh */
// Widths assume 64-bit request and memory data, 64-byte lines and 8-byte reservation words
`ifndef UC_CONSTS_SVH
`define UC_CONSTS_SVH

// Request address width
`define UC_ADDR_W 32

// Request and memory data width
`define UC_DATA_W 64

// One byte enable per data byte
`define UC_BE_W 8

// Log2 of the access size in bytes
`define UC_SIZE_W 3

// Core transaction id
`define UC_TID_W 4

// Byte offset inside a 64-byte cache line
`define UC_LINE_OFS_W 6

// Byte offset inside the 8-byte reservation word
`define UC_WORD_OFS_W 3

// SC return code on failure where success is zero
`define UC_SC_FAIL 1

`endif

/* uc_pkg.sv */
// Encodings of core operations and memory commands; every op value is legal, so no error code
package uc_pkg;

    // Core side operation
    typedef enum logic [3:0] {
        OP_LD   = 4'd0,
        OP_ST   = 4'd1,
        OP_LR   = 4'd2,
        OP_SC   = 4'd3,
        OP_SWAP = 4'd4,
        OP_ADD  = 4'd5,
        OP_AND  = 4'd6,
        OP_OR   = 4'd7,
        OP_XOR  = 4'd8,
        OP_MAX  = 4'd9,
        OP_MAXU = 4'd10,
        OP_MIN  = 4'd11,
        OP_MINU = 4'd12
    } uc_op_e;

    // Memory request command
    typedef enum logic [1:0] {
        CMD_READ   = 2'd0,
        CMD_WRITE  = 2'd1,
        CMD_ATOMIC = 2'd2
    } mem_cmd_e;

    // Atomic kind, only meaningful with CMD_ATOMIC
    typedef enum logic [3:0] {
        AMO_LDEX = 4'd0,
        AMO_STEX = 4'd1,
        AMO_SWAP = 4'd2,
        AMO_ADD  = 4'd3,
        AMO_CLR  = 4'd4,
        AMO_SET  = 4'd5,
        AMO_EOR  = 4'd6,
        AMO_SMAX = 4'd7,
        AMO_UMAX = 4'd8,
        AMO_SMIN = 4'd9,
        AMO_UMIN = 4'd10
    } mem_atomic_e;

endpackage

/* uc_lrsc_rsrv.sv */
// One reservation of an 8-byte word; snoops match at word granularity within a single line
`include "uc_consts.svh"

module uc_lrsc_rsrv (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  set_i,
    input  logic                  clear_i,
    input  logic [`UC_ADDR_W-1:0] set_addr_i,
    input  logic [`UC_ADDR_W-1:0] req_addr_i,
    input  logic                  snoop_i,
    input  logic [`UC_ADDR_W-1:0] snoop_addr_i,
    input  logic [`UC_SIZE_W-1:0] snoop_size_i,
    output logic                  req_hit_o
);
    localparam int WIDX_W = `UC_LINE_OFS_W - `UC_WORD_OFS_W;

    logic                  valid_q;
    logic [`UC_ADDR_W-1:0] addr_q;
    logic [WIDX_W+1:0]     rsv_word;
    logic [WIDX_W+1:0]     snoop_base;
    logic [WIDX_W+1:0]     snoop_words;
    logic [WIDX_W+1:0]     snoop_end;
    logic                  snoop_line_eq;
    logic                  snoop_hit;

    assign rsv_word   = {2'b00, addr_q[`UC_WORD_OFS_W +: WIDX_W]};
    assign snoop_base = {2'b00, snoop_addr_i[`UC_WORD_OFS_W +: WIDX_W]};

    // Accesses below one word still cover a whole word
    assign snoop_words = (snoop_size_i > `UC_SIZE_W'(`UC_WORD_OFS_W)) ?
        ((WIDX_W+2)'(1) << (snoop_size_i - `UC_SIZE_W'(`UC_WORD_OFS_W))) : (WIDX_W+2)'(1);
    assign snoop_end  = snoop_base + snoop_words;

    assign snoop_line_eq = addr_q[`UC_ADDR_W-1:`UC_LINE_OFS_W] ==
                           snoop_addr_i[`UC_ADDR_W-1:`UC_LINE_OFS_W];
    assign snoop_hit = snoop_i & valid_q & snoop_line_eq &
                       (rsv_word >= snoop_base) & (rsv_word < snoop_end);

    // Same line and same word
    assign req_hit_o = valid_q & (addr_q[`UC_ADDR_W-1:`UC_WORD_OFS_W] ==
                                  req_addr_i[`UC_ADDR_W-1:`UC_WORD_OFS_W]);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (clear_i || snoop_hit) begin
            valid_q <= 1'b0;
        end else if (set_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_i) begin
            addr_q <= set_addr_i;
        end
    end

endmodule

/* uc_req_encode.sv */
// Combinational; LD and LR use the read channel, all other ops use the write channels
`include "uc_consts.svh"

module uc_req_encode (
    input  uc_pkg::uc_op_e        op_i,
    input  logic [`UC_DATA_W-1:0] data_i,
    output uc_pkg::mem_cmd_e      rd_cmd_o,
    output uc_pkg::mem_atomic_e   rd_atomic_o,
    output uc_pkg::mem_cmd_e      wr_cmd_o,
    output uc_pkg::mem_atomic_e   wr_atomic_o,
    output logic [`UC_DATA_W-1:0] wdata_o
);

    // LR is an exclusive load on the read channel
    always_comb begin
        if (op_i == uc_pkg::OP_LR) begin
            rd_cmd_o    = uc_pkg::CMD_ATOMIC;
            rd_atomic_o = uc_pkg::AMO_LDEX;
        end else begin
            rd_cmd_o    = uc_pkg::CMD_READ;
            rd_atomic_o = uc_pkg::AMO_ADD;
        end
    end

    always_comb begin
        wr_cmd_o    = uc_pkg::CMD_ATOMIC;
        wr_atomic_o = uc_pkg::AMO_ADD;
        wdata_o     = data_i;
        case (op_i)
            uc_pkg::OP_SC:   wr_atomic_o = uc_pkg::AMO_STEX;
            uc_pkg::OP_SWAP: wr_atomic_o = uc_pkg::AMO_SWAP;
            uc_pkg::OP_ADD:  wr_atomic_o = uc_pkg::AMO_ADD;
            // AND is done by memory as a bit clear of the inverted operand
            uc_pkg::OP_AND: begin
                wr_atomic_o = uc_pkg::AMO_CLR;
                wdata_o     = ~data_i;
            end
            uc_pkg::OP_OR:   wr_atomic_o = uc_pkg::AMO_SET;
            uc_pkg::OP_XOR:  wr_atomic_o = uc_pkg::AMO_EOR;
            uc_pkg::OP_MAX:  wr_atomic_o = uc_pkg::AMO_SMAX;
            uc_pkg::OP_MAXU: wr_atomic_o = uc_pkg::AMO_UMAX;
            uc_pkg::OP_MIN:  wr_atomic_o = uc_pkg::AMO_SMIN;
            uc_pkg::OP_MINU: wr_atomic_o = uc_pkg::AMO_UMIN;
            default:         wr_cmd_o    = uc_pkg::CMD_WRITE;
        endcase
    end

endmodule

/* uc_ctrl_fsm.sv */
// One request in flight; memory responses are always accepted and must follow their request
`include "uc_consts.svh"

module uc_ctrl_fsm (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_valid_i,
    input  uc_pkg::uc_op_e        req_op_i,
    input  logic [`UC_ADDR_W-1:0] req_addr_i,
    input  logic [`UC_SIZE_W-1:0] req_size_i,
    input  logic [`UC_DATA_W-1:0] req_data_i,
    input  logic [`UC_BE_W-1:0]   req_be_i,
    input  logic [`UC_TID_W-1:0]  req_tid_i,
    input  logic                  req_need_rsp_i,
    input  logic                  cache_idle_i,
    input  logic                  lrsc_hit_i,
    input  logic                  mem_rd_ready_i,
    input  logic                  mem_wr_ready_i,
    input  logic                  mem_wd_ready_i,
    input  logic                  mem_rrsp_valid_i,
    input  logic                  mem_rrsp_error_i,
    input  logic                  mem_wrsp_valid_i,
    input  logic                  mem_wrsp_error_i,
    input  logic                  core_rsp_ready_i,
    output logic                  req_ready_o,
    output logic                  mem_rd_valid_o,
    output logic                  mem_wr_valid_o,
    output logic                  mem_wd_valid_o,
    output uc_pkg::uc_op_e        op_o,
    output logic [`UC_ADDR_W-1:0] addr_o,
    output logic [`UC_SIZE_W-1:0] size_o,
    output logic [`UC_DATA_W-1:0] data_o,
    output logic [`UC_BE_W-1:0]   be_o,
    output logic [`UC_TID_W-1:0]  tid_o,
    output logic                  rsv_set_o,
    output logic                  rsv_clear_o,
    output logic                  sc_fail_local_o,
    output logic                  capture_rd_o,
    output logic                  error_set_o,
    output logic                  core_rsp_valid_o
);
    typedef enum logic [2:0] {
        IDLE, WAIT_PENDING, MEM_REQ, MEM_W_REQ, MEM_WDATA_REQ, MEM_WAIT_RSP, CORE_RSP
    } state_e;

    state_e state_q, state_d;
    logic   need_rsp_q;
    logic   rrsp_seen_q, wrsp_seen_q;
    logic   is_rd, is_amo, in_req_amo;
    logic   rd_done, wr_done, rsp_window;

    assign is_rd      = (op_o == uc_pkg::OP_LD) || (op_o == uc_pkg::OP_LR);
    assign is_amo     = op_o inside {uc_pkg::OP_SWAP, uc_pkg::OP_ADD, uc_pkg::OP_AND,
                                     uc_pkg::OP_OR, uc_pkg::OP_XOR, uc_pkg::OP_MAX,
                                     uc_pkg::OP_MAXU, uc_pkg::OP_MIN, uc_pkg::OP_MINU};
    assign in_req_amo = req_op_i inside {uc_pkg::OP_SWAP, uc_pkg::OP_ADD, uc_pkg::OP_AND,
                                         uc_pkg::OP_OR, uc_pkg::OP_XOR, uc_pkg::OP_MAX,
                                         uc_pkg::OP_MAXU, uc_pkg::OP_MIN, uc_pkg::OP_MINU};

    // AMO responses may come back before the write channels both finish
    assign rsp_window = state_q inside {MEM_W_REQ, MEM_WDATA_REQ, MEM_WAIT_RSP};
    assign rd_done    = mem_rrsp_valid_i | rrsp_seen_q;
    assign wr_done    = mem_wrsp_valid_i | wrsp_seen_q;

    assign req_ready_o      = (state_q == IDLE);
    assign core_rsp_valid_o = (state_q == CORE_RSP);
    assign mem_rd_valid_o   = (state_q == MEM_REQ) & is_rd;
    assign mem_wr_valid_o   = ((state_q == MEM_REQ) & ~is_rd) | (state_q == MEM_W_REQ);
    assign mem_wd_valid_o   = ((state_q == MEM_REQ) & ~is_rd) | (state_q == MEM_WDATA_REQ);
    assign capture_rd_o     = rsp_window & mem_rrsp_valid_i;
    assign error_set_o      = rsp_window & ((mem_rrsp_valid_i & mem_rrsp_error_i) |
                                            (mem_wrsp_valid_i & mem_wrsp_error_i));

    always_comb begin
        state_d         = state_q;
        rsv_set_o       = 1'b0;
        rsv_clear_o     = 1'b0;
        sc_fail_local_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    rsv_clear_o = (in_req_amo & lrsc_hit_i) | (req_op_i == uc_pkg::OP_SC);
                    if ((req_op_i == uc_pkg::OP_SC) && !lrsc_hit_i) begin
                        sc_fail_local_o = 1'b1;
                        state_d         = CORE_RSP;
                    end else begin
                        state_d = cache_idle_i ? MEM_REQ : WAIT_PENDING;
                    end
                end
            end
            WAIT_PENDING: begin
                if (cache_idle_i) begin
                    state_d = MEM_REQ;
                end
            end
            MEM_REQ: begin
                if (is_rd) begin
                    if (mem_rd_ready_i) begin
                        state_d = MEM_WAIT_RSP;
                    end
                end else if (mem_wr_ready_i && mem_wd_ready_i) begin
                    state_d = MEM_WAIT_RSP;
                end else if (mem_wr_ready_i) begin
                    state_d = MEM_WDATA_REQ;
                end else if (mem_wd_ready_i) begin
                    state_d = MEM_W_REQ;
                end
            end
            MEM_W_REQ: begin
                if (mem_wr_ready_i) begin
                    state_d = MEM_WAIT_RSP;
                end
            end
            MEM_WDATA_REQ: begin
                if (mem_wd_ready_i) begin
                    state_d = MEM_WAIT_RSP;
                end
            end
            MEM_WAIT_RSP: begin
                if (is_amo) begin
                    if (rd_done && wr_done) begin
                        state_d = CORE_RSP;
                    end
                end else if (op_o == uc_pkg::OP_LR) begin
                    if (mem_rrsp_valid_i) begin
                        // An failed LR must not leave a reservation behind
                        rsv_set_o   = ~mem_rrsp_error_i;
                        rsv_clear_o = mem_rrsp_error_i;
                        state_d     = CORE_RSP;
                    end
                end else if (is_rd ? rd_done : wr_done) begin
                    state_d = (need_rsp_q || op_o == uc_pkg::OP_SC) ? CORE_RSP : IDLE;
                end
            end
            CORE_RSP: begin
                if (core_rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            rrsp_seen_q <= 1'b0;
            wrsp_seen_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == MEM_REQ) begin
                rrsp_seen_q <= 1'b0;
                wrsp_seen_q <= 1'b0;
            end else if (rsp_window) begin
                rrsp_seen_q <= rrsp_seen_q | mem_rrsp_valid_i;
                wrsp_seen_q <= wrsp_seen_q | mem_wrsp_valid_i;
            end
        end
    end

    // Request is held for the whole transaction
    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            op_o       <= req_op_i;
            addr_o     <= req_addr_i;
            size_o     <= req_size_i;
            data_o     <= req_data_i;
            be_o       <= req_be_i;
            tid_o      <= req_tid_i;
            need_rsp_q <= req_need_rsp_i;
        end
    end

endmodule

/* uc_rsp_fmt.sv */
// SC return code is only placed in rdata for an SC; 4-byte SC repeats it in both halves
`include "uc_consts.svh"

module uc_rsp_fmt (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  capture_rd_i,
    input  logic [`UC_DATA_W-1:0] rd_data_i,
    input  logic                  error_set_i,
    input  logic                  error_clr_i,
    input  uc_pkg::uc_op_e        sc_i,
    input  logic                  sc_fail_local_i,
    input  logic                  wrsp_atomic_i,
    input  logic                  wrsp_valid_i,
    input  logic [`UC_SIZE_W-1:0] size_i,
    output logic [`UC_DATA_W-1:0] rdata_o,
    output logic                  error_o
);
    logic [`UC_DATA_W-1:0] rd_data_q;
    logic                  sc_code_q;
    logic [`UC_DATA_W-1:0] sc_rdata;

    always_ff @(posedge clk_i) begin
        if (capture_rd_i) begin
            rd_data_q <= rd_data_i;
        end
        // Success only when memory confirms the exclusive store
        if (sc_fail_local_i) begin
            sc_code_q <= 1'(`UC_SC_FAIL);
        end else if (wrsp_valid_i) begin
            sc_code_q <= (wrsp_atomic_i && !error_set_i) ? ~1'(`UC_SC_FAIL) : 1'(`UC_SC_FAIL);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            error_o <= 1'b0;
        end else if (error_set_i) begin
            error_o <= 1'b1;
        end else if (error_clr_i) begin
            error_o <= 1'b0;
        end
    end

    assign sc_rdata = (size_i == `UC_SIZE_W'(2)) ? {2{32'(sc_code_q)}} : `UC_DATA_W'(sc_code_q);
    assign rdata_o  = (sc_i == uc_pkg::OP_SC) ? sc_rdata : rd_data_q;

endmodule

/* uc_handler.sv */
// Uncached handler top; every request is uncached and the cache must report idle before issue
`include "uc_consts.svh"

module uc_handler (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  uc_pkg::uc_op_e        req_op_i,
    input  logic [`UC_ADDR_W-1:0] req_addr_i,
    input  logic [`UC_SIZE_W-1:0] req_size_i,
    input  logic [`UC_DATA_W-1:0] req_data_i,
    input  logic [`UC_BE_W-1:0]   req_be_i,
    input  logic [`UC_TID_W-1:0]  req_tid_i,
    input  logic                  req_need_rsp_i,
    output logic                  core_rsp_valid_o,
    input  logic                  core_rsp_ready_i,
    output logic [`UC_DATA_W-1:0] core_rsp_rdata_o,
    output logic [`UC_TID_W-1:0]  core_rsp_tid_o,
    output logic                  core_rsp_error_o,
    output logic                  mem_rd_valid_o,
    input  logic                  mem_rd_ready_i,
    output logic [`UC_ADDR_W-1:0] mem_rd_addr_o,
    output logic [`UC_SIZE_W-1:0] mem_rd_size_o,
    output uc_pkg::mem_cmd_e      mem_rd_cmd_o,
    output uc_pkg::mem_atomic_e   mem_rd_atomic_o,
    output logic                  mem_wr_valid_o,
    input  logic                  mem_wr_ready_i,
    output logic [`UC_ADDR_W-1:0] mem_wr_addr_o,
    output logic [`UC_SIZE_W-1:0] mem_wr_size_o,
    output uc_pkg::mem_cmd_e      mem_wr_cmd_o,
    output uc_pkg::mem_atomic_e   mem_wr_atomic_o,
    output logic                  mem_wd_valid_o,
    input  logic                  mem_wd_ready_i,
    output logic [`UC_DATA_W-1:0] mem_wd_data_o,
    output logic [`UC_BE_W-1:0]   mem_wd_be_o,
    input  logic                  mem_rrsp_valid_i,
    input  logic [`UC_DATA_W-1:0] mem_rrsp_data_i,
    input  logic                  mem_rrsp_error_i,
    input  logic                  mem_wrsp_valid_i,
    input  logic                  mem_wrsp_error_i,
    input  logic                  mem_wrsp_atomic_i,
    input  logic                  lrsc_snoop_i,
    input  logic [`UC_ADDR_W-1:0] lrsc_snoop_addr_i,
    input  logic [`UC_SIZE_W-1:0] lrsc_snoop_size_i,
    input  logic                  cache_idle_i
);
    uc_pkg::uc_op_e        op;
    logic [`UC_ADDR_W-1:0] addr;
    logic [`UC_SIZE_W-1:0] size;
    logic [`UC_DATA_W-1:0] data;
    logic                  lrsc_hit, rsv_set, rsv_clear, sc_fail_local;
    logic                  capture_rd, error_set;

    assign mem_rd_addr_o = addr;
    assign mem_wr_addr_o = addr;
    assign mem_rd_size_o = size;
    assign mem_wr_size_o = size;

    uc_ctrl_fsm u_ctrl (
        .clk_i, .rst_ni, .req_valid_i, .req_op_i, .req_addr_i, .req_size_i,
        .req_data_i, .req_be_i, .req_tid_i, .req_need_rsp_i, .cache_idle_i,
        .lrsc_hit_i(lrsc_hit), .mem_rd_ready_i, .mem_wr_ready_i, .mem_wd_ready_i,
        .mem_rrsp_valid_i, .mem_rrsp_error_i, .mem_wrsp_valid_i, .mem_wrsp_error_i,
        .core_rsp_ready_i, .req_ready_o, .mem_rd_valid_o, .mem_wr_valid_o,
        .mem_wd_valid_o, .op_o(op), .addr_o(addr), .size_o(size), .data_o(data),
        .be_o(mem_wd_be_o), .tid_o(core_rsp_tid_o), .rsv_set_o(rsv_set),
        .rsv_clear_o(rsv_clear), .sc_fail_local_o(sc_fail_local),
        .capture_rd_o(capture_rd), .error_set_o(error_set), .core_rsp_valid_o
    );

    uc_lrsc_rsrv u_rsrv (
        .clk_i, .rst_ni, .set_i(rsv_set), .clear_i(rsv_clear), .set_addr_i(addr),
        .req_addr_i, .snoop_i(lrsc_snoop_i), .snoop_addr_i(lrsc_snoop_addr_i),
        .snoop_size_i(lrsc_snoop_size_i), .req_hit_o(lrsc_hit)
    );

    uc_req_encode u_encode (
        .op_i(op), .data_i(data), .rd_cmd_o(mem_rd_cmd_o), .rd_atomic_o(mem_rd_atomic_o),
        .wr_cmd_o(mem_wr_cmd_o), .wr_atomic_o(mem_wr_atomic_o), .wdata_o(mem_wd_data_o)
    );

    // Sticky error is cleared while idle
    uc_rsp_fmt u_fmt (
        .clk_i, .rst_ni, .capture_rd_i(capture_rd), .rd_data_i(mem_rrsp_data_i),
        .error_set_i(error_set), .error_clr_i(req_ready_o), .sc_i(op),
        .sc_fail_local_i(sc_fail_local), .wrsp_atomic_i(mem_wrsp_atomic_i),
        .wrsp_valid_i(mem_wrsp_valid_i), .size_i(size), .rdata_o(core_rsp_rdata_o),
        .error_o(core_rsp_error_o)
    );

endmodule

/* tb_uc_handler.sv */
// Single-request random traffic from a fixed-seed LFSR; snoops only arrive between requests
`include "uc_consts.svh"

module tb_uc_handler;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TXN = 300;

    logic                  clk_i, rst_ni, cache_idle_i;
    logic                  req_valid_i, req_ready_o, req_need_rsp_i;
    uc_pkg::uc_op_e        req_op_i;
    logic [`UC_ADDR_W-1:0] req_addr_i, mem_rd_addr_o, mem_wr_addr_o, lrsc_snoop_addr_i;
    logic [`UC_SIZE_W-1:0] req_size_i, mem_rd_size_o, mem_wr_size_o, lrsc_snoop_size_i;
    logic [`UC_DATA_W-1:0] req_data_i, core_rsp_rdata_o, mem_wd_data_o, mem_rrsp_data_i;
    logic [`UC_BE_W-1:0]   req_be_i, mem_wd_be_o;
    logic [`UC_TID_W-1:0]  req_tid_i, core_rsp_tid_o;
    logic                  core_rsp_valid_o, core_rsp_ready_i, core_rsp_error_o;
    logic                  mem_rd_valid_o, mem_rd_ready_i, mem_wr_valid_o, mem_wr_ready_i;
    logic                  mem_wd_valid_o, mem_wd_ready_i;
    uc_pkg::mem_cmd_e      mem_rd_cmd_o, mem_wr_cmd_o;
    uc_pkg::mem_atomic_e   mem_rd_atomic_o, mem_wr_atomic_o;
    logic                  mem_rrsp_valid_i, mem_rrsp_error_i;
    logic                  mem_wrsp_valid_i, mem_wrsp_error_i, mem_wrsp_atomic_i;
    logic                  lrsc_snoop_i;

    // Stimulus source and reservation model
    logic [31:0]           lfsr_q = 32'h48ff_3f33;
    logic                  rsv_valid = 1'b0;
    logic [`UC_ADDR_W-1:0] rsv_addr = '0;
    int                    errors = 0;
    int                    checks = 0;
    int                    failed = 0;

    uc_handler dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_q[0];
            lfsr_q = (lfsr_q >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            r = {r[62:0], b};
        end
        return r;
    endfunction

    // SC return code as placed in rdata with both halves set for 4-byte accesses
    function automatic logic [63:0] sc_word(input logic fail, input logic [2:0] size);
        if (size == 3'd2) begin
            return {31'd0, fail, 31'd0, fail};
        end
        return {63'd0, fail};
    endfunction

    function automatic uc_pkg::mem_atomic_e amo_kind(input uc_pkg::uc_op_e op);
        case (op)
            uc_pkg::OP_SC:   return uc_pkg::AMO_STEX;
            uc_pkg::OP_SWAP: return uc_pkg::AMO_SWAP;
            uc_pkg::OP_ADD:  return uc_pkg::AMO_ADD;
            uc_pkg::OP_AND:  return uc_pkg::AMO_CLR;
            uc_pkg::OP_OR:   return uc_pkg::AMO_SET;
            uc_pkg::OP_XOR:  return uc_pkg::AMO_EOR;
            uc_pkg::OP_MAX:  return uc_pkg::AMO_SMAX;
            uc_pkg::OP_MAXU: return uc_pkg::AMO_UMAX;
            uc_pkg::OP_MIN:  return uc_pkg::AMO_SMIN;
            default:         return uc_pkg::AMO_UMIN;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
        checks++;
        assert (act === exp) else begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_cond(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic check_mem_valids(input logic rd, input logic wr, input logic wd);
        check_val("mem_rd_valid_o", 64'(mem_rd_valid_o), 64'(rd));
        check_val("mem_wr_valid_o", 64'(mem_wr_valid_o), 64'(wr));
        check_val("mem_wd_valid_o", 64'(mem_wd_valid_o), 64'(wd));
    endtask

    // Inputs change 1 ns after the edge and outputs are sampled mid cycle
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic settle();
        #4;
    endtask

    // Occasional snoop in an idle cycle between requests
    task automatic maybe_snoop();
        logic [2:0]  ssize;
        logic [31:0] saddr, last_byte;
        if (take_bits(2) == 64'd0) begin
            ssize = 3'(take_bits(3));
            if (ssize == 3'd7) begin
                ssize = 3'd6;
            end
            saddr = (32'h4000_0000 | 32'(take_bits(7))) & ~((32'd1 << ssize) - 32'd1);
            last_byte = saddr + (32'd1 << ssize) - 32'd1;
            lrsc_snoop_i = 1'b1;
            lrsc_snoop_addr_i = saddr;
            lrsc_snoop_size_i = ssize;
            // Any snooped byte inside the reserved word kills it
            if (rsv_valid && saddr[31:6] == rsv_addr[31:6] && saddr[31:3] <= rsv_addr[31:3]
                && last_byte[31:3] >= rsv_addr[31:3]) begin
                rsv_valid = 1'b0;
            end
            next_cycle();
            lrsc_snoop_i = 1'b0;
        end
    endtask

    task automatic run_txn(input int n);
        uc_pkg::uc_op_e   op;
        uc_pkg::mem_cmd_e rd_cmd, wr_cmd;
        logic [3:0]       sel, tid;
        logic [2:0]       size, isel;
        logic [31:0]      addr;
        logic [63:0]      data, rdata, exp_rdata;
        logic [7:0]       be;
        logic need_rsp, hit, local_fail, use_rd, need_r, need_w, rerr, werr, watomic;
        logic exp_err, expect_rsp, rd_done, wr_done, wd_done, rsp_done;
        int   idle_delay, dr, dw, last, guard, err_before;

        err_before = errors;
        sel = 4'(take_bits(4));
        // Spare codes go to LR and SC so reservations get exercised
        if (sel > 4'd12) begin
            sel = (sel == 4'd13) ? 4'd2 : 4'd3;
        end
        op = uc_pkg::uc_op_e'(sel);
        size = 3'd2 + 3'(take_bits(1));
        addr = 32'h4000_0000 | 32'(take_bits(4) << 3);
        if (size == 3'd2) begin
            addr = addr | 32'(take_bits(1) << 2);
        end
        // Half of the requests made while a reservation is held go to its word
        if (rsv_valid && take_bits(1) == 64'd1) begin
            addr[31:3] = rsv_addr[31:3];
        end
        data = take_bits(64);
        be = 8'(take_bits(8));
        tid = 4'(take_bits(4));
        need_rsp = 1'(take_bits(1));
        isel = 3'(take_bits(3));
        idle_delay = (isel > 3'd3) ? 0 : int'(isel);
        dr = int'(take_bits(2));
        dw = int'(take_bits(2));
        rdata = take_bits(64);
        rerr = (take_bits(3) == 64'd7);
        werr = (take_bits(3) == 64'd7);
        watomic = (take_bits(2) != 64'd0);

        // Reservation rules at acceptance
        hit = rsv_valid && (rsv_addr[31:3] == addr[31:3]);
        local_fail = (op == uc_pkg::OP_SC) && !hit;
        if (op == uc_pkg::OP_SC || (op >= uc_pkg::OP_SWAP && hit)) begin
            rsv_valid = 1'b0;
        end
        use_rd = (op == uc_pkg::OP_LD) || (op == uc_pkg::OP_LR);
        need_r = use_rd || (op >= uc_pkg::OP_SWAP);
        need_w = !use_rd;
        rd_cmd = (op == uc_pkg::OP_LR) ? uc_pkg::CMD_ATOMIC : uc_pkg::CMD_READ;
        wr_cmd = (op == uc_pkg::OP_ST) ? uc_pkg::CMD_WRITE : uc_pkg::CMD_ATOMIC;
        expect_rsp = need_rsp || !(op == uc_pkg::OP_LD || op == uc_pkg::OP_ST);
        exp_err = (need_r && rerr) || (need_w && werr);
        exp_rdata = (op == uc_pkg::OP_SC) ? sc_word(!(watomic && !werr), size) : rdata;

        req_valid_i = 1'b1;
        req_op_i = op;
        req_addr_i = addr;
        req_size_i = size;
        req_data_i = data;
        req_be_i = be;
        req_tid_i = tid;
        req_need_rsp_i = need_rsp;
        cache_idle_i = (idle_delay == 0);
        settle();
        check_val("req_ready_o", 64'(req_ready_o), 64'd1);
        next_cycle();
        req_valid_i = 1'b0;

        if (local_fail) begin
            cache_idle_i = 1'b1;
            exp_rdata = sc_word(1'b1, size);
            exp_err = 1'b0;
        end else begin
            // Nothing may issue until the cache reports idle
            for (int i = 0; i < idle_delay; i++) begin
                cache_idle_i = (i == idle_delay - 1);
                settle();
                check_mem_valids(1'b0, 1'b0, 1'b0);
                next_cycle();
            end
            rd_done = !use_rd;
            wr_done = use_rd;
            wd_done = use_rd;
            guard = 0;
            while (!(rd_done && wr_done && wd_done) && guard < 64) begin
                mem_rd_ready_i = 1'(take_bits(1));
                mem_wr_ready_i = 1'(take_bits(1));
                mem_wd_ready_i = 1'(take_bits(1));
                settle();
                check_mem_valids(!rd_done, !wr_done, !wd_done);
                if (!rd_done) begin
                    check_val("mem_rd_addr_o", 64'(mem_rd_addr_o), 64'(addr));
                    check_val("mem_rd_size_o", 64'(mem_rd_size_o), 64'(size));
                    check_val("mem_rd_cmd_o", 64'(mem_rd_cmd_o), 64'(rd_cmd));
                    if (op == uc_pkg::OP_LR) begin
                        check_val("mem_rd_atomic_o", 64'(mem_rd_atomic_o),
                                  64'(uc_pkg::AMO_LDEX));
                    end
                end
                if (!wr_done) begin
                    check_val("mem_wr_addr_o", 64'(mem_wr_addr_o), 64'(addr));
                    check_val("mem_wr_size_o", 64'(mem_wr_size_o), 64'(size));
                    check_val("mem_wr_cmd_o", 64'(mem_wr_cmd_o), 64'(wr_cmd));
                    if (wr_cmd == uc_pkg::CMD_ATOMIC) begin
                        check_val("mem_wr_atomic_o", 64'(mem_wr_atomic_o), 64'(amo_kind(op)));
                    end
                end
                if (!wd_done) begin
                    // Memory clears the bits that are set in the operand
                    check_val("mem_wd_data_o", mem_wd_data_o,
                              (op == uc_pkg::OP_AND) ? ~data : data);
                    check_val("mem_wd_be_o", 64'(mem_wd_be_o), 64'(be));
                end
                rd_done = rd_done | mem_rd_ready_i;
                wr_done = wr_done | mem_wr_ready_i;
                wd_done = wd_done | mem_wd_ready_i;
                next_cycle();
                guard++;
            end
            mem_rd_ready_i = 1'b0;
            mem_wr_ready_i = 1'b0;
            mem_wd_ready_i = 1'b0;
            check_cond(guard < 64, "memory request handshakes did not complete");

            // Responder sends AMO responses in any order or together
            mem_rrsp_data_i = rdata;
            mem_rrsp_error_i = rerr;
            mem_wrsp_error_i = werr;
            mem_wrsp_atomic_i = watomic;
            last = need_r ? dr : 0;
            if (need_w && dw > last) begin
                last = dw;
            end
            for (int c = 0; c <= last; c++) begin
                mem_rrsp_valid_i = need_r && (c == dr);
                mem_wrsp_valid_i = need_w && (c == dw);
                settle();
                check_mem_valids(1'b0, 1'b0, 1'b0);
                check_val("core_rsp_valid_o", 64'(core_rsp_valid_o), 64'd0);
                next_cycle();
            end
            mem_rrsp_valid_i = 1'b0;
            mem_wrsp_valid_i = 1'b0;
            if (op == uc_pkg::OP_LR) begin
                rsv_valid = !rerr;
                rsv_addr = addr;
            end
        end

        if (expect_rsp) begin
            rsp_done = 1'b0;
            guard = 0;
            while (!rsp_done && guard < 64) begin
                core_rsp_ready_i = 1'(take_bits(1));
                settle();
                check_val("core_rsp_valid_o", 64'(core_rsp_valid_o), 64'd1);
                check_val("core_rsp_tid_o", 64'(core_rsp_tid_o), 64'(tid));
                check_val("core_rsp_error_o", 64'(core_rsp_error_o), 64'(exp_err));
                if (op != uc_pkg::OP_ST) begin
                    check_val("core_rsp_rdata_o", core_rsp_rdata_o, exp_rdata);
                end
                rsp_done = core_rsp_ready_i;
                next_cycle();
                guard++;
            end
            core_rsp_ready_i = 1'b0;
            check_cond(rsp_done, "core response handshake did not complete");
        end
        settle();
        check_val("core_rsp_valid_o", 64'(core_rsp_valid_o), 64'd0);
        check_val("req_ready_o", 64'(req_ready_o), 64'd1);
        next_cycle();
        if (errors != err_before) begin
            failed++;
        end
        $display("txn %0d %s addr %h: %s", n, op.name(), addr,
                 (errors == err_before) ? "passed" : "failed");
    endtask

    initial begin
        rst_ni = 1'b0;
        cache_idle_i = 1'b1;
        req_valid_i = 1'b0;
        req_op_i = uc_pkg::OP_LD;
        req_addr_i = '0;
        req_size_i = '0;
        req_data_i = '0;
        req_be_i = '0;
        req_tid_i = '0;
        req_need_rsp_i = 1'b0;
        core_rsp_ready_i = 1'b0;
        mem_rd_ready_i = 1'b0;
        mem_wr_ready_i = 1'b0;
        mem_wd_ready_i = 1'b0;
        mem_rrsp_valid_i = 1'b0;
        mem_rrsp_data_i = '0;
        mem_rrsp_error_i = 1'b0;
        mem_wrsp_valid_i = 1'b0;
        mem_wrsp_error_i = 1'b0;
        mem_wrsp_atomic_i = 1'b0;
        lrsc_snoop_i = 1'b0;
        lrsc_snoop_addr_i = '0;
        lrsc_snoop_size_i = '0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        settle();
        check_mem_valids(1'b0, 1'b0, 1'b0);
        check_val("core_rsp_valid_o", 64'(core_rsp_valid_o), 64'd0);
        check_val("req_ready_o", 64'(req_ready_o), 64'd1);
        if (errors != 0) begin
            failed++;
        end
        $display("reset state: %s", (errors == 0) ? "passed" : "failed");
        next_cycle();
        for (int n = 0; n < NUM_TXN; n++) begin
            maybe_snoop();
            run_txn(n);
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
                 NUM_TXN + 1, NUM_TXN + 1 - failed, failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Worst case per request stays well under 200 cycles
    initial begin
        #(NUM_TXN * 200 * 10);
        $display("Watchdog expired after %0d cycles, the run did not finish", NUM_TXN * 200);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
uc_pkg.sv
uc_lrsc_rsrv.sv
uc_req_encode.sv
uc_ctrl_fsm.sv
uc_rsp_fmt.sv
uc_handler.sv
tb_uc_handler.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line in the log
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_uc_handler -f verilog.f -o sim_uc_handler
./obj_dir/sim_uc_handler | tee sim.log
grep -q "^Test OK$" sim.log
echo "Simulation passed"
